// File: rtl/uninasoc_params.svh
`ifndef UNINASOC_PARAMS_SVH
`define UNINASOC_PARAMS_SVH

// bus geometry
`define DATA_WIDTH   32
`define ADDR_WIDTH   32
`define STRB_WIDTH   (`DATA_WIDTH / 8)
`define IRQ_LINES    32

// memory map, 4 KiB regions except the plic
`define MEM_WORDS    1024
`define MEM_BASE     32'h0000_0000
`define PBUS_BASE    32'h1000_0000
`define PLIC_BASE    32'h0C00_0000
`define REGION_MASK  32'h0000_0FFF
`define PLIC_MASK    32'h003F_FFFF

// peripherals and interrupt numbering
`define NUM_GPIO_IN  8
`define NUM_GPIO_OUT 8
`define PBUS_INT_NUM 2
`define PLIC_SRC_NUM 3
`define EXT_INT_PIN  11

// peripheral bus register offsets
`define GPIO_OUT     32'h0000_0000
`define GPIO_IN      32'h0000_0004
`define GPIO_IE      32'h0000_0008
`define TIM_CMP      32'h0000_0010
`define TIM_CTRL     32'h0000_0014
`define TIM_STAT     32'h0000_0018

// plic register offsets
`define PLIC_PEND    32'h0000_1000
`define PLIC_EN      32'h0000_2000
`define PLIC_CLAIM   32'h0020_0004

`endif

// File: rtl/uninasoc_pkg.sv
`include "uninasoc_params.svh"

package uninasoc_pkg;

    typedef logic [`ADDR_WIDTH-1:0]           addr_t;     // byte address
    typedef logic [`DATA_WIDTH-1:0]           data_t;
    typedef logic [`STRB_WIDTH-1:0]           strb_t;     // one bit per byte lane
    typedef logic [`NUM_GPIO_IN-1:0]          gpio_in_t;
    typedef logic [`NUM_GPIO_OUT-1:0]         gpio_out_t;
    typedef logic [`PBUS_INT_NUM-1:0]         pbus_int_t; // level lines to the plic
    typedef logic [`IRQ_LINES-1:0]            irq_line_t; // socket interrupt vector
    typedef logic [$clog2(`PLIC_SRC_NUM)-1:0] plic_id_t;

    typedef enum logic [1:0] {
        SEL_MEM,
        SEL_PBUS,
        SEL_PLIC,
        SEL_NONE    // unmapped, answered by the bus itself
    } slave_sel_t;

    typedef enum logic {
        MST_IDLE,   // grant open
        MST_WAIT    // request out, waiting on the slave
    } master_state_t;

    // byte-lane write merge
    function automatic data_t merge_be(data_t old_v, data_t new_v, strb_t be);
        data_t res;
        res = old_v;
        for (int b = 0; b < `STRB_WIDTH; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_v[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage : uninasoc_pkg

// File: rtl/sys_master.sv
module sys_master (
    input  logic                sys_clock_i,
    input  logic                arst_n_i,
    // host port
    input  logic                host_req_i,
    input  logic                host_we_i,
    input  uninasoc_pkg::addr_t host_addr_i,
    input  uninasoc_pkg::data_t host_wdata_i,
    input  uninasoc_pkg::strb_t host_be_i,
    output logic                host_gnt_o,
    output logic                host_rvalid_o,
    output uninasoc_pkg::data_t host_rdata_o,
    output logic                host_err_o,
    // main bus
    output logic                bus_req_o,
    output logic                bus_we_o,
    output uninasoc_pkg::addr_t bus_addr_o,
    output uninasoc_pkg::data_t bus_wdata_o,
    output uninasoc_pkg::strb_t bus_be_o,
    input  logic                bus_rvalid_i,
    input  uninasoc_pkg::data_t bus_rdata_i,
    input  logic                bus_err_i
);

    import uninasoc_pkg::*;

    master_state_t state_q;
    logic          accept;

    assign host_gnt_o = (state_q == MST_IDLE);   // single transaction in flight
    assign accept     = host_req_i && host_gnt_o;

    always_ff @(posedge sys_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= MST_IDLE;
            bus_req_o     <= 1'b0;
            host_rvalid_o <= 1'b0;
            host_err_o    <= 1'b0;
        end else begin
            bus_req_o     <= accept;              // one cycle strobe
            host_rvalid_o <= 1'b0;
            case (state_q)
                MST_IDLE: begin
                    if (accept) begin
                        state_q <= MST_WAIT;
                    end
                end
                MST_WAIT: begin
                    if (bus_rvalid_i) begin
                        state_q       <= MST_IDLE;
                        host_rvalid_o <= 1'b1;    // response pulse
                        host_err_o    <= bus_err_i;
                    end
                end
                default: state_q <= MST_IDLE;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge sys_clock_i) begin
        if (accept) begin
            bus_we_o    <= host_we_i;
            bus_addr_o  <= host_addr_i;
            bus_wdata_o <= host_wdata_i;
            bus_be_o    <= host_be_i;
        end
        if (state_q == MST_WAIT && bus_rvalid_i) begin
            host_rdata_o <= (bus_we_o || bus_err_i) ? '0 : bus_rdata_i;  // writes read zero
        end
    end

    // every response must belong to the request sent out
    assert property (@(posedge sys_clock_i) disable iff (!arst_n_i)
        bus_rvalid_i |-> state_q == MST_WAIT);

endmodule : sys_master

// File: rtl/main_bus.sv
`include "uninasoc_params.svh"

module main_bus (
    input  logic                sys_clock_i,
    input  logic                arst_n_i,
    // from sys_master
    input  logic                bus_req_i,
    input  logic                bus_we_i,
    input  uninasoc_pkg::addr_t bus_addr_i,
    input  uninasoc_pkg::data_t bus_wdata_i,
    input  uninasoc_pkg::strb_t bus_be_i,
    output logic                bus_rvalid_o,
    output uninasoc_pkg::data_t bus_rdata_o,
    output logic                bus_err_o,
    // slave requests
    output logic                mem_req_o,
    output logic                pbus_req_o,
    output logic                plic_req_o,
    output logic                slv_we_o,
    output uninasoc_pkg::addr_t slv_addr_o,
    output uninasoc_pkg::data_t slv_wdata_o,
    output uninasoc_pkg::strb_t slv_be_o,
    // slave responses
    input  logic                mem_rvalid_i,
    input  uninasoc_pkg::data_t mem_rdata_i,
    input  logic                pbus_rvalid_i,
    input  uninasoc_pkg::data_t pbus_rdata_i,
    input  logic                plic_rvalid_i,
    input  uninasoc_pkg::data_t plic_rdata_i
);

    import uninasoc_pkg::*;

    slave_sel_t sel;
    logic       err_q;   // decode error response

    //////////////////////////////
    // address decode
    //////////////////////////////

    always_comb begin
        if ((bus_addr_i & ~`REGION_MASK) == `MEM_BASE) begin
            sel = SEL_MEM;
        end else if ((bus_addr_i & ~`REGION_MASK) == `PBUS_BASE) begin
            sel = SEL_PBUS;
        end else if ((bus_addr_i & ~`PLIC_MASK) == `PLIC_BASE) begin
            sel = SEL_PLIC;   // wide 4 MiB window
        end else begin
            sel = SEL_NONE;
        end
    end

    assign mem_req_o   = bus_req_i && (sel == SEL_MEM);
    assign pbus_req_o  = bus_req_i && (sel == SEL_PBUS);
    assign plic_req_o  = bus_req_i && (sel == SEL_PLIC);
    assign slv_we_o    = bus_we_i;
    assign slv_addr_o  = bus_addr_i & ((sel == SEL_PLIC) ? `PLIC_MASK : `REGION_MASK);
    assign slv_wdata_o = bus_wdata_i;
    assign slv_be_o    = bus_be_i;

    //////////////////////////////
    // responses
    //////////////////////////////

    always_ff @(posedge sys_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= bus_req_i && (sel == SEL_NONE);   // answer like a slave would
        end
    end

    always_comb begin
        case (1'b1)
            mem_rvalid_i:  bus_rdata_o = mem_rdata_i;
            pbus_rvalid_i: bus_rdata_o = pbus_rdata_i;
            plic_rvalid_i: bus_rdata_o = plic_rdata_i;
            default:       bus_rdata_o = '0;   // error carries zero
        endcase
    end

    assign bus_rvalid_o = mem_rvalid_i || pbus_rvalid_i || plic_rvalid_i || err_q;
    assign bus_err_o    = err_q;

    // one slave addressed, and no two answers in the same cycle
    assert property (@(posedge sys_clock_i) disable iff (!arst_n_i)
        $onehot0({mem_req_o, pbus_req_o, plic_req_o})
        && $onehot0({mem_rvalid_i, pbus_rvalid_i, plic_rvalid_i, err_q}));

endmodule : main_bus

// File: rtl/main_memory.sv
`include "uninasoc_params.svh"

module main_memory (
    input  logic                sys_clock_i,
    input  logic                arst_n_i,
    input  logic                req_i,
    input  logic                we_i,
    input  uninasoc_pkg::addr_t addr_i,
    input  uninasoc_pkg::data_t wdata_i,
    input  uninasoc_pkg::strb_t be_i,
    output logic                rvalid_o,
    output uninasoc_pkg::data_t rdata_o
);

    import uninasoc_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);

    data_t            mem_q [`MEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = addr_i[IDX_W+1:2];   // word index, byte offset dropped

    always_ff @(posedge sys_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= req_i;   // fixed one cycle latency
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[idx] <= merge_be(mem_q[idx], wdata_i, be_i);
            end
            rdata_o <= mem_q[idx];   // old word on a write
        end
    end

endmodule : main_memory

// File: rtl/peripheral_bus.sv
`include "uninasoc_params.svh"

module peripheral_bus (
    input  logic                    sys_clock_i,
    input  logic                    arst_n_i,
    input  logic                    req_i,
    input  logic                    we_i,
    input  uninasoc_pkg::addr_t     addr_i,   // region offset
    input  uninasoc_pkg::data_t     wdata_i,
    input  uninasoc_pkg::strb_t     be_i,
    output logic                    rvalid_o,
    output uninasoc_pkg::data_t     rdata_o,
    input  uninasoc_pkg::gpio_in_t  gpio_in_i,
    output uninasoc_pkg::gpio_out_t gpio_out_o,
    output uninasoc_pkg::pbus_int_t int_o
);

    import uninasoc_pkg::*;

    gpio_in_t gpio_in_q;    // sampled pins
    gpio_in_t gpio_ie_q;    // per pin interrupt enable
    data_t    tim_cnt_q;
    data_t    tim_cmp_q;
    logic     tim_en_q;
    logic     tim_stat_q;   // sticky match
    logic     wr;

    assign wr = req_i && we_i;

    always_ff @(posedge sys_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_in_q  <= '0;
            gpio_out_o <= '0;
            gpio_ie_q  <= '0;
            tim_cnt_q  <= '0;
            tim_cmp_q  <= '0;
            tim_en_q   <= 1'b0;
            tim_stat_q <= 1'b0;
            rvalid_o   <= 1'b0;
        end else begin
            gpio_in_q <= gpio_in_i;
            rvalid_o  <= req_i;
            //////////////////////////////
            // timer
            //////////////////////////////
            if (tim_en_q) begin
                if (tim_cnt_q == tim_cmp_q) begin
                    tim_cnt_q  <= '0;      // restart on match
                    tim_stat_q <= 1'b1;
                end else begin
                    tim_cnt_q <= tim_cnt_q + 1'b1;
                end
            end
            //////////////////////////////
            // register writes
            //////////////////////////////
            if (wr) begin
                case (addr_i)
                    `GPIO_OUT: gpio_out_o <= gpio_out_t'(merge_be(gpio_out_o, wdata_i, be_i));
                    `GPIO_IE:  gpio_ie_q  <= gpio_in_t'(merge_be(gpio_ie_q, wdata_i, be_i));
                    `TIM_CMP:  tim_cmp_q  <= merge_be(tim_cmp_q, wdata_i, be_i);
                    `TIM_CTRL: tim_en_q   <= wdata_i[0];
                    `TIM_STAT: begin
                        if (wdata_i[0]) begin
                            tim_stat_q <= 1'b0;   // write one to clear
                        end
                    end
                    default: ;                    // gpio_in is read only
                endcase
            end
        end
    end

    // read data
    always_ff @(posedge sys_clock_i) begin
        if (req_i) begin
            case (addr_i)
                `GPIO_OUT: rdata_o <= data_t'(gpio_out_o);
                `GPIO_IN:  rdata_o <= data_t'(gpio_in_q);
                `GPIO_IE:  rdata_o <= data_t'(gpio_ie_q);
                `TIM_CMP:  rdata_o <= tim_cmp_q;
                `TIM_CTRL: rdata_o <= data_t'(tim_en_q);
                `TIM_STAT: rdata_o <= data_t'(tim_stat_q);
                default:   rdata_o <= '0;
            endcase
        end
    end

    assign int_o[0] = |(gpio_in_q & gpio_ie_q);   // level, any enabled pin
    assign int_o[1] = tim_stat_q;

endmodule : peripheral_bus

// File: rtl/custom_rv_plic.sv
`include "uninasoc_params.svh"

module custom_rv_plic (
    input  logic                    sys_clock_i,
    input  logic                    arst_n_i,
    input  logic                    req_i,
    input  logic                    we_i,
    input  uninasoc_pkg::addr_t     addr_i,   // offset in the 4 MiB window
    input  uninasoc_pkg::data_t     wdata_i,
    input  uninasoc_pkg::strb_t     be_i,
    output logic                    rvalid_o,
    output uninasoc_pkg::data_t     rdata_o,
    input  uninasoc_pkg::pbus_int_t intr_src_i,
    output uninasoc_pkg::irq_line_t socket_irq_o
);

    import uninasoc_pkg::*;

    logic [`PLIC_SRC_NUM-1:0] src;            // source 0 reserved, tied low
    logic [`PLIC_SRC_NUM-1:0] pending_q;
    logic [`PLIC_SRC_NUM-1:0] enable_q;
    logic [`PLIC_SRC_NUM-1:0] in_service_q;   // claimed, not yet completed
    logic [`PLIC_SRC_NUM-1:0] claim_mask;
    logic [`PLIC_SRC_NUM-1:0] complete_mask;
    plic_id_t                 claim_id;
    logic                     claim_rd;
    logic                     complete_wr;

    assign src         = {intr_src_i, 1'b0};
    assign claim_rd    = req_i && !we_i && (addr_i == `PLIC_CLAIM);
    assign complete_wr = req_i && we_i && be_i[0] && (addr_i == `PLIC_CLAIM);

    always_comb begin
        claim_id = '0;   // nothing to claim
        for (int i = `PLIC_SRC_NUM - 1; i > 0; i--) begin
            if (pending_q[i] && enable_q[i]) begin
                claim_id = plic_id_t'(i);   // lowest id wins
            end
        end
        for (int i = 0; i < `PLIC_SRC_NUM; i++) begin
            claim_mask[i]    = claim_rd && (i != 0) && (claim_id == plic_id_t'(i));
            complete_mask[i] = complete_wr && (plic_id_t'(wdata_i) == plic_id_t'(i));
        end
    end

    always_ff @(posedge sys_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q    <= '0;
            enable_q     <= '0;
            in_service_q <= '0;
            rvalid_o     <= 1'b0;
        end else begin
            rvalid_o     <= req_i;
            // gateway, a level source pends again only after completion
            pending_q    <= (pending_q | (src & ~in_service_q)) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
            if (req_i && we_i && be_i[0] && addr_i == `PLIC_EN) begin
                enable_q <= {wdata_i[`PLIC_SRC_NUM-1:1], 1'b0};
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (req_i) begin
            case (addr_i)
                `PLIC_PEND:  rdata_o <= data_t'(pending_q);
                `PLIC_EN:    rdata_o <= data_t'(enable_q);
                `PLIC_CLAIM: rdata_o <= data_t'(claim_id);
                default:     rdata_o <= '0;
            endcase
        end
    end

    // only the external interrupt pin of the socket is used
    always_comb begin
        socket_irq_o               = '0;
        socket_irq_o[`EXT_INT_PIN] = |(pending_q & enable_q);
    end

    // completed id is one that a claim can return
    assert property (@(posedge sys_clock_i) disable iff (!arst_n_i)
        complete_wr |-> wdata_i < `PLIC_SRC_NUM);

endmodule : custom_rv_plic

// File: rtl/uninasoc.sv
module uninasoc (
    input  logic                    sys_clock_i,
    input  logic                    arst_n_i,
    // host port
    input  logic                    host_req_i,
    input  logic                    host_we_i,
    input  uninasoc_pkg::addr_t     host_addr_i,
    input  uninasoc_pkg::data_t     host_wdata_i,
    input  uninasoc_pkg::strb_t     host_be_i,
    output logic                    host_gnt_o,
    output logic                    host_rvalid_o,
    output uninasoc_pkg::data_t     host_rdata_o,
    output logic                    host_err_o,
    // gpio and interrupts
    input  uninasoc_pkg::gpio_in_t  gpio_in_i,
    output uninasoc_pkg::gpio_out_t gpio_out_o,
    output uninasoc_pkg::irq_line_t socket_irq_o
);

    import uninasoc_pkg::*;

    // sys_master -> main_bus
    logic      bus_req;
    logic      bus_we;
    addr_t     bus_addr;
    data_t     bus_wdata;
    strb_t     bus_be;
    logic      bus_rvalid;
    data_t     bus_rdata;
    logic      bus_err;
    // main_bus -> slaves
    logic      mem_req;
    logic      pbus_req;
    logic      plic_req;
    logic      slv_we;
    addr_t     slv_addr;
    data_t     slv_wdata;
    strb_t     slv_be;
    logic      mem_rvalid;
    data_t     mem_rdata;
    logic      pbus_rvalid;
    data_t     pbus_rdata;
    logic      plic_rvalid;
    data_t     plic_rdata;
    pbus_int_t pbus_int;   // pbus -> plic

    sys_master sys_master_u (
        .sys_clock_i, .arst_n_i,
        .host_req_i, .host_we_i, .host_addr_i, .host_wdata_i, .host_be_i,
        .host_gnt_o, .host_rvalid_o, .host_rdata_o, .host_err_o,
        .bus_req_o    ( bus_req    ),
        .bus_we_o     ( bus_we     ),
        .bus_addr_o   ( bus_addr   ),
        .bus_wdata_o  ( bus_wdata  ),
        .bus_be_o     ( bus_be     ),
        .bus_rvalid_i ( bus_rvalid ),
        .bus_rdata_i  ( bus_rdata  ),
        .bus_err_i    ( bus_err    )
    );

    main_bus main_bus_u (
        .sys_clock_i, .arst_n_i,
        .bus_req_i     ( bus_req     ),
        .bus_we_i      ( bus_we      ),
        .bus_addr_i    ( bus_addr    ),
        .bus_wdata_i   ( bus_wdata   ),
        .bus_be_i      ( bus_be      ),
        .bus_rvalid_o  ( bus_rvalid  ),
        .bus_rdata_o   ( bus_rdata   ),
        .bus_err_o     ( bus_err     ),
        .mem_req_o     ( mem_req     ),
        .pbus_req_o    ( pbus_req    ),
        .plic_req_o    ( plic_req    ),
        .slv_we_o      ( slv_we      ),
        .slv_addr_o    ( slv_addr    ),
        .slv_wdata_o   ( slv_wdata   ),
        .slv_be_o      ( slv_be      ),
        .mem_rvalid_i  ( mem_rvalid  ),
        .mem_rdata_i   ( mem_rdata   ),
        .pbus_rvalid_i ( pbus_rvalid ),
        .pbus_rdata_i  ( pbus_rdata  ),
        .plic_rvalid_i ( plic_rvalid ),
        .plic_rdata_i  ( plic_rdata  )
    );

    main_memory main_memory_u (
        .sys_clock_i, .arst_n_i,
        .req_i    ( mem_req    ),
        .we_i     ( slv_we     ),
        .addr_i   ( slv_addr   ),
        .wdata_i  ( slv_wdata  ),
        .be_i     ( slv_be     ),
        .rvalid_o ( mem_rvalid ),
        .rdata_o  ( mem_rdata  )
    );

    peripheral_bus peripheral_bus_u (
        .sys_clock_i, .arst_n_i,
        .req_i      ( pbus_req    ),
        .we_i       ( slv_we      ),
        .addr_i     ( slv_addr    ),
        .wdata_i    ( slv_wdata   ),
        .be_i       ( slv_be      ),
        .rvalid_o   ( pbus_rvalid ),
        .rdata_o    ( pbus_rdata  ),
        .gpio_in_i, .gpio_out_o,
        .int_o      ( pbus_int    )
    );

    custom_rv_plic custom_rv_plic_u (
        .sys_clock_i, .arst_n_i,
        .req_i        ( plic_req    ),
        .we_i         ( slv_we      ),
        .addr_i       ( slv_addr    ),
        .wdata_i      ( slv_wdata   ),
        .be_i         ( slv_be      ),
        .rvalid_o     ( plic_rvalid ),
        .rdata_o      ( plic_rdata  ),
        .intr_src_i   ( pbus_int    ),   // line 0 -> source 1, line 1 -> source 2
        .socket_irq_o
    );

endmodule : uninasoc

// File: tests/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        $display("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_gpio(input string name, input gpio_out_t got, input gpio_out_t exp);
    if (got !== exp) begin
        $display("ERR %0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_irq(input string name, input irq_line_t got, input irq_line_t exp);
    if (got !== exp) begin
        $display("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_err(input string name, input bit got, input bit exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %0b expected %0b", $time, name, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("ERR %0t %s got %0d expected %0d cycles", $time, name, got, exp);
        stop_with_failure();
    end
endtask

//////////////////////////////
// host port access
//////////////////////////////

task automatic host_access(input logic we, input addr_t addr, input data_t wdata,
                           input strb_t be, output data_t rdata, output logic err);
    int lat;
    @(posedge sys_clock);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    host_be    <= be;
    do begin
        @(negedge sys_clock);   // grant only moves on the rising edge
    end while (!host_gnt);
    @(posedge sys_clock);       // accepting edge
    host_req <= 1'b0;
    lat = 0;
    do begin
        @(negedge sys_clock);
        lat++;
    end while (!host_rvalid);
    rdata = host_rdata;
    err   = host_err;
    check_latency("host_rvalid_o", lat, 3);
endtask

task automatic host_write(input addr_t addr, input data_t wdata, input strb_t be,
                          input logic exp_err);
    data_t rd;
    logic  er;
    host_access(1'b1, addr, wdata, be, rd, er);
    check_err("host_err_o", er, exp_err);
    check_data("host_rdata_o", rd, '0);   // write response carries zero
endtask

task automatic host_read(input addr_t addr, input logic exp_err, output data_t rdata);
    logic er;
    host_access(1'b0, addr, '0, 4'hF, rdata, er);
    check_err("host_err_o", er, exp_err);
endtask

`endif

// File: tests/tb_uninasoc.sv
`include "uninasoc_params.svh"

module tb_uninasoc;

    import uninasoc_pkg::*;

    localparam int N_MEM_OPS   = 200;
    localparam int N_FIXED     = 40;
    localparam int TIM_CMP_MAX = 64;
    localparam int N_WINDOW    = 16;   // memory words under test
    localparam int CYCLE_LIMIT = 4 * (N_MEM_OPS + N_FIXED) + 2 * TIM_CMP_MAX + 200;

    logic      sys_clock;
    logic      arst_n;
    logic      host_req;
    logic      host_we;
    addr_t     host_addr;
    data_t     host_wdata;
    strb_t     host_be;
    logic      host_gnt;
    logic      host_rvalid;
    data_t     host_rdata;
    logic      host_err;
    gpio_in_t  gpio_in;
    gpio_out_t gpio_out;
    irq_line_t socket_irq;
    int        cycles = 0;

    // reference model
    data_t                    mem_model [`MEM_WORDS];
    gpio_out_t                gpio_model;
    logic [`PLIC_SRC_NUM-1:0] pend_model;
    logic [`PLIC_SRC_NUM-1:0] en_model;
    logic [`PLIC_SRC_NUM-1:0] insvc_model;   // claimed, not completed

    uninasoc u_dut (
        .sys_clock_i   ( sys_clock   ),
        .arst_n_i      ( arst_n      ),
        .host_req_i    ( host_req    ),
        .host_we_i     ( host_we     ),
        .host_addr_i   ( host_addr   ),
        .host_wdata_i  ( host_wdata  ),
        .host_be_i     ( host_be     ),
        .host_gnt_o    ( host_gnt    ),
        .host_rvalid_o ( host_rvalid ),
        .host_rdata_o  ( host_rdata  ),
        .host_err_o    ( host_err    ),
        .gpio_in_i     ( gpio_in     ),
        .gpio_out_o    ( gpio_out    ),
        .socket_irq_o  ( socket_irq  )
    );

    `include "tb_tasks.svh"

    initial begin
        sys_clock = 1'b0;
        forever #20 sys_clock = ~sys_clock;
    end

    always @(posedge sys_clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: simulation ran past its cycle limit");
            stop_with_failure();
        end
    end

    //////////////////////////////
    // model helpers
    //////////////////////////////

    function automatic data_t apply_strobes(data_t old_w, data_t new_w, strb_t be);
        data_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic int word_of(int k);
        return k * 67;   // window spread over the whole memory
    endfunction

    function automatic irq_line_t irq_expected();
        irq_line_t v;
        v = '0;
        v[`EXT_INT_PIN] = |(pend_model & en_model);
        return v;
    endfunction

    function automatic data_t claim_expected();
        for (int id = 1; id < `PLIC_SRC_NUM; id++) begin
            if (pend_model[id] && en_model[id]) return data_t'(id);   // lowest id first
        end
        return '0;
    endfunction

    task automatic plic_enable(input data_t mask);
        host_write(`PLIC_BASE + `PLIC_EN, mask, 4'hF, 1'b0);
        en_model    = mask[`PLIC_SRC_NUM-1:0];
        en_model[0] = 1'b0;   // source 0 reserved
    endtask

    task automatic plic_claim();
        data_t exp_id;
        data_t rd;
        exp_id = claim_expected();
        host_read(`PLIC_BASE + `PLIC_CLAIM, 1'b0, rd);
        check_data("host_rdata_o", rd, exp_id);
        if (exp_id != '0) begin
            pend_model[int'(exp_id)]  = 1'b0;
            insvc_model[int'(exp_id)] = 1'b1;
        end
    endtask

    task automatic plic_complete(input int id);
        host_write(`PLIC_BASE + `PLIC_CLAIM, data_t'(id), 4'hF, 1'b0);
        insvc_model[id] = 1'b0;
    endtask

    task automatic wait_irq(input int max_cycles, input string what);
        int n;
        n = 0;
        do begin
            @(negedge sys_clock);
            n++;
        end while (socket_irq == '0 && n < max_cycles);
        if (socket_irq == '0) begin
            $display("%s did not reach socket_irq_o within %0d cycles", what, max_cycles);
            stop_with_failure();
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        data_t    rd;
        data_t    wd;
        strb_t    be;
        gpio_in_t gin;
        int       k;
        int       pin;
        int       cmp;
        void'($urandom(454));
        arst_n      = 1'b0;
        host_req    = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        host_be     = '0;
        gpio_in     = '0;
        gpio_model  = '0;
        pend_model  = '0;
        en_model    = '0;
        insvc_model = '0;
        repeat (8) @(posedge sys_clock);
        arst_n <= 1'b1;
        @(negedge sys_clock);
        check_err("host_gnt_o", host_gnt, 1'b1);
        check_err("host_rvalid_o", host_rvalid, 1'b0);
        check_gpio("gpio_out_o", gpio_out, '0);
        check_irq("socket_irq_o", socket_irq, '0);

        // main memory, full words first so every read is known
        for (k = 0; k < N_WINDOW; k++) begin
            wd = $urandom;
            host_write(`MEM_BASE + addr_t'(4 * word_of(k)), wd, 4'hF, 1'b0);
            mem_model[word_of(k)] = wd;
        end
        for (int i = 0; i < N_MEM_OPS; i++) begin
            k = $urandom_range(N_WINDOW - 1, 0);
            if ($urandom_range(1, 0) == 1) begin
                wd = $urandom;
                be = strb_t'($urandom);
                host_write(`MEM_BASE + addr_t'(4 * word_of(k)), wd, be, 1'b0);
                mem_model[word_of(k)] = apply_strobes(mem_model[word_of(k)], wd, be);
            end else begin
                host_read(`MEM_BASE + addr_t'(4 * word_of(k)), 1'b0, rd);
                check_data("host_rdata_o", rd, mem_model[word_of(k)]);
            end
        end

        // unmapped, low bits alias memory word 0
        host_write(32'h2000_0000, $urandom, 4'hF, 1'b1);
        host_read(32'h2000_0000, 1'b1, rd);
        check_data("host_rdata_o", rd, '0);
        host_read(`MEM_BASE, 1'b0, rd);
        check_data("host_rdata_o", rd, mem_model[0]);

        // gpio out and in
        for (int i = 0; i < 3; i++) begin
            wd = $urandom;
            be = strb_t'($urandom);
            host_write(`PBUS_BASE + `GPIO_OUT, wd, be, 1'b0);
            if (be[0]) gpio_model = gpio_out_t'(wd);   // byte lane 0 only
            check_gpio("gpio_out_o", gpio_out, gpio_model);
            host_read(`PBUS_BASE + `GPIO_OUT, 1'b0, rd);
            check_data("host_rdata_o", rd, data_t'(gpio_model));
        end
        gin = gpio_in_t'($urandom);
        @(posedge sys_clock);
        gpio_in <= gin;
        repeat (3) @(posedge sys_clock);
        host_read(`PBUS_BASE + `GPIO_IN, 1'b0, rd);
        check_data("host_rdata_o", rd, data_t'(gin));

        // gpio interrupt through plic source 1
        @(posedge sys_clock);
        gpio_in <= '0;
        repeat (3) @(posedge sys_clock);
        pin = $urandom_range(`NUM_GPIO_IN - 1, 0);
        host_write(`PBUS_BASE + `GPIO_IE, data_t'(1) << pin, 4'hF, 1'b0);
        plic_enable(32'h2);
        check_irq("socket_irq_o", socket_irq, irq_expected());
        @(posedge sys_clock);
        gpio_in <= gpio_in_t'(1 << pin);
        wait_irq(4, "GPIO interrupt");
        pend_model[1] = 1'b1;
        check_irq("socket_irq_o", socket_irq, irq_expected());
        plic_claim();
        // input still high but held off by the gateway
        pend_model[1] = pend_model[1] | ~insvc_model[1];
        check_irq("socket_irq_o", socket_irq, irq_expected());
        @(posedge sys_clock);
        gpio_in <= '0;
        repeat (3) @(posedge sys_clock);
        plic_complete(1);
        repeat (2) @(negedge sys_clock);
        check_irq("socket_irq_o", socket_irq, irq_expected());

        // timer interrupt through plic source 2
        cmp = $urandom_range(TIM_CMP_MAX - 1, 0);
        host_write(`PBUS_BASE + `TIM_CMP, data_t'(cmp), 4'hF, 1'b0);
        plic_enable(32'h4);
        check_irq("socket_irq_o", socket_irq, irq_expected());
        host_write(`PBUS_BASE + `TIM_CTRL, 32'h1, 4'hF, 1'b0);
        wait_irq(2 * TIM_CMP_MAX, "timer interrupt");
        pend_model[2] = 1'b1;
        check_irq("socket_irq_o", socket_irq, irq_expected());
        plic_claim();
        host_write(`PBUS_BASE + `TIM_CTRL, 32'h0, 4'hF, 1'b0);   // stop before clearing
        host_write(`PBUS_BASE + `TIM_STAT, 32'h1, 4'hF, 1'b0);
        plic_complete(2);
        repeat (2) @(negedge sys_clock);
        check_irq("socket_irq_o", socket_irq, irq_expected());

        $display("Test completed successfully");
        $finish;
    end

endmodule : tb_uninasoc

// File: compile.f
+incdir+rtl
+incdir+tests
rtl/uninasoc_pkg.sv
rtl/sys_master.sv
rtl/main_bus.sv
rtl/main_memory.sv
rtl/peripheral_bus.sv
rtl/custom_rv_plic.sv
rtl/uninasoc.sv
tests/tb_uninasoc.sv

// File: Makefile
# Verilator build and run for the SoC testbench

VERILATOR ?= verilator
TOP       ?= tb_uninasoc
LOG       ?= sim.log
FLIST     ?= compile.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FLIST)

run: compile
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)
